//--- hdl/cam_params_pkg.sv
`default_nettype none

// Sizing constants of the CAM
// Shared by the tag directory, the data RAM and the top level
package cam_params_pkg;

  // Tag width
  // Tags come from the surrounding system and are stored as given
  localparam int TAG_WIDTH = 8;

  // Width of one stored data word
  localparam int DATA_WIDTH = 16;

  // Number of slots
  // Same count in the directory and in the data RAM
  localparam int DEPTH = 16;

  // Width of a slot number
  // Base-2 logarithm of DEPTH
  localparam int INDEX_WIDTH = $clog2(DEPTH);

endpackage

`default_nettype wire

//--- hdl/cam_types_pkg.sv
`default_nettype none

// Data types carried on the CAM ports and between its blocks
package cam_types_pkg;

  import cam_params_pkg::*;

  // One tag as supplied by the system
  typedef logic [TAG_WIDTH-1:0] cam_tag_t;

  // One stored data word
  typedef logic [DATA_WIDTH-1:0] cam_data_t;

  // Slot number in the directory and the RAM
  typedef logic [INDEX_WIDTH-1:0] cam_index_t;

  // Write request
  // Stores data under the tag in the lowest free slot
  typedef struct packed {
    // One-cycle strobe
    logic      enable;
    cam_tag_t  tag;
    cam_data_t data;
  } cam_write_req_t;

  // Search request
  // Same shape for read and for delete
  typedef struct packed {
    // One-cycle strobe
    logic     enable;
    cam_tag_t tag;
  } cam_search_req_t;

  // Read response, one cycle after the read strobe
  typedef struct packed {
    // Tag found and not deleted in the same cycle
    logic      hit;
    // Zero on a miss
    cam_data_t data;
  } cam_read_rsp_t;

endpackage

`default_nettype wire

//--- hdl/tag_directory.sv
`timescale 1ns/1ps
`default_nettype none

// Tag directory of the CAM
// One valid bit and one tag register per slot
// Parallel search over all valid slots
// Lowest free slot picked for allocation
module tag_directory
  import cam_params_pkg::*;
  import cam_types_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  // Allocation request from the write port
  input  logic       allocate_enable,
  input  cam_tag_t   allocate_tag,
  // High only when enabled and a slot is free
  output logic       allocate_grant,
  output cam_index_t allocate_index,
  // Combinational search
  input  cam_tag_t   search_tag,
  output logic       search_hit,
  output cam_index_t search_index,
  // Slot release
  input  logic       evict_enable,
  input  cam_index_t evict_index,
  // Registered occupancy flags
  output logic       full,
  output logic       empty
);

  // Slot state
  logic [DEPTH-1:0]     valid_q;
  cam_tag_t [DEPTH-1:0] tag_q;

  // Per-slot comparison result
  logic [DEPTH-1:0] match;

  // Free slot encoder result
  logic slot_free;

  // Valid vector after this edge
  logic [DEPTH-1:0] valid_next;

  // Compare the search tag with every slot
  // Invalid slots never match
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      match[i] = valid_q[i] && (tag_q[i] == search_tag);
    end
  end

  // Any match is a hit
  assign search_hit = |match;

  // One-hot to binary
  // OR of the matching indices, exact since at most one slot matches
  always_comb begin
    search_index = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (match[i]) begin
        search_index = search_index | cam_index_t'(i);
      end
    end
  end

  // Priority encoder on the free slots
  // Scan from the top so that the lowest free slot is written last
  always_comb begin
    slot_free      = 1'b0;
    allocate_index = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        slot_free      = 1'b1;
        allocate_index = cam_index_t'(i);
      end
    end
  end

  // Write while full is dropped here
  assign allocate_grant = allocate_enable && slot_free;

  // Next valid vector
  // Allocated slot was free at the start of the cycle
  // Evicted slot was valid, so the two never collide
  always_comb begin
    valid_next = valid_q;
    if (evict_enable) begin
      valid_next[evict_index] = 1'b0;
    end
    if (allocate_grant) begin
      valid_next[allocate_index] = 1'b1;
    end
  end

  // Valid bits and flags
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_q <= '0;
      full    <= 1'b0;
      empty   <= 1'b1;
    end else begin
      valid_q <= valid_next;
      // Flags follow the new state one cycle after the update
      full    <= &valid_next;
      empty   <= ~|valid_next;
    end
  end

  // Tag storage
  // Only read through a set valid bit
  always_ff @(posedge clock) begin
    if (allocate_grant) begin
      tag_q[allocate_index] <= allocate_tag;
    end
  end

  // Unique tags keep the search result to one slot at most
  a_single_match : assert property (
    @(posedge clock) disable iff (!rst_n)
    $onehot0(match)
  ) else $error("tag_directory: several slots match tag %h", search_tag);

  // Evictions only target a live slot
  a_evict_valid : assert property (
    @(posedge clock) disable iff (!rst_n)
    evict_enable |-> valid_q[evict_index]
  ) else $error("tag_directory: evict of free slot %0d", evict_index);

endmodule

`default_nettype wire

//--- hdl/simple_dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual port RAM
// One synchronous write port and one registered read port
// Payload type set by the instance
module simple_dual_port_ram
  import cam_params_pkg::*;
  import cam_types_pkg::*;
#(
  parameter type payload_t = cam_data_t
) (
  input  logic       clock,
  // Write port
  input  logic       write_enable,
  input  cam_index_t write_address,
  input  payload_t   write_data,
  // Read port, data one cycle after the enable
  input  logic       read_enable,
  input  cam_index_t read_address,
  output payload_t   read_data
);

  // Storage array
  payload_t memory [DEPTH];

  // Write at the edge
  always_ff @(posedge clock) begin
    if (write_enable) begin
      memory[write_address] <= write_data;
    end
  end

  // Registered read
  // Same address as the write gives the old word
  // Output holds while the read is idle
  always_ff @(posedge clock) begin
    if (read_enable) begin
      read_data <= memory[read_address];
    end
  end

endmodule

`default_nettype wire

//--- hdl/content_addressable_memory.sv
`timescale 1ns/1ps
`default_nettype none

// Content addressable memory
// Write stores data under a system tag in the lowest free slot
// Read returns hit and data one cycle after the strobe
// Delete frees the slot holding the tag
// Delete and read share one search port, delete wins
module content_addressable_memory
  import cam_params_pkg::*;
  import cam_types_pkg::*;
(
  input  logic            clock,
  input  logic            rst_n,
  // Write port
  input  cam_write_req_t  write_req,
  // Search ports
  input  cam_search_req_t read_req,
  input  cam_search_req_t delete_req,
  // Read result
  output cam_read_rsp_t   read_rsp,
  // Occupancy
  output logic            full,
  output logic            empty
);

  // Directory signals
  logic       allocate_grant;
  cam_index_t allocate_index;
  cam_tag_t   search_tag;
  logic       search_hit;
  cam_index_t search_index;
  logic       evict_enable;

  // RAM read side
  logic      ram_read_enable;
  cam_data_t ram_read_data;

  // Hit delayed to meet the RAM data
  logic hit_q;

  // Tags and valid bits
  tag_directory i_tag_directory (
    .clock           ( clock            ),
    .rst_n           ( rst_n            ),
    .allocate_enable ( write_req.enable ),
    .allocate_tag    ( write_req.tag    ),
    .allocate_grant  ( allocate_grant   ),
    .allocate_index  ( allocate_index   ),
    .search_tag      ( search_tag       ),
    .search_hit      ( search_hit       ),
    .search_index    ( search_index     ),
    .evict_enable    ( evict_enable     ),
    .evict_index     ( search_index     ),
    .full            ( full             ),
    .empty           ( empty            )
  );

  // Data words, one per slot
  simple_dual_port_ram #(
    .payload_t ( cam_data_t )
  ) i_data_ram (
    .clock         ( clock           ),
    .write_enable  ( allocate_grant  ),
    .write_address ( allocate_index  ),
    .write_data    ( write_req.data  ),
    .read_enable   ( ram_read_enable ),
    .read_address  ( search_index    ),
    .read_data     ( ram_read_data   )
  );

  // Search arbitration
  // Delete tag takes the port whenever delete is strobed
  assign search_tag = delete_req.enable ? delete_req.tag : read_req.tag;

  // Free the slot of a found delete tag
  assign evict_enable = delete_req.enable && search_hit;

  // RAM read only for a read that won the port and hit
  assign ram_read_enable = read_req.enable && !delete_req.enable && search_hit;

  // Hit register
  // Same edge as the RAM read register
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= ram_read_enable;
    end
  end

  // Response
  // Data forced to zero on a miss since the RAM output holds stale words
  assign read_rsp.hit  = hit_q;
  assign read_rsp.data = hit_q ? ram_read_data : '0;

  // True when the tag sits in a valid directory slot
  function automatic logic tag_is_stored(
    input logic [DEPTH-1:0]     valid,
    input cam_tag_t [DEPTH-1:0] tags,
    input cam_tag_t             tag
  );
    logic found;
    found = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i] && (tags[i] == tag)) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // A write never brings a tag that the directory already holds
  a_write_tag_unique : assert property (
    @(posedge clock) disable iff (!rst_n)
    write_req.enable |->
      !tag_is_stored(i_tag_directory.valid_q, i_tag_directory.tag_q, write_req.tag)
  ) else $error("content_addressable_memory: write of stored tag %h", write_req.tag);

endmodule

`default_nettype wire

//--- verif/cam_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the content addressable memory
// A tag-to-data model predicts read_rsp, full and empty for every cycle
// Concurrent assertions compare the DUT with the model at each edge
module cam_tb
  import cam_params_pkg::*;
  import cam_types_pkg::*;
();

  localparam int RESET_CYCLES  = 4;
  localparam int RANDOM_CYCLES = 400;

  // Cycles driven by each test, two closing idle cycles included
  localparam int BASIC_CYCLES  = 6;
  localparam int MISS_CYCLES   = 5;
  localparam int DELETE_CYCLES = 9;
  localparam int FULL_CYCLES   = 3 * DEPTH + 4;
  localparam int MIXED_CYCLES  = 10;
  localparam int RANDOM_TOTAL  = RANDOM_CYCLES + 2;

  localparam int STIMULUS_CYCLES = RESET_CYCLES + BASIC_CYCLES + MISS_CYCLES + DELETE_CYCLES
                                 + FULL_CYCLES + MIXED_CYCLES + RANDOM_TOTAL;
  localparam int CYCLE_LIMIT = 2 * STIMULUS_CYCLES + 100;

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_SEED = 32'h789f677c;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  localparam cam_write_req_t  NO_WRITE  = '0;
  localparam cam_search_req_t NO_SEARCH = '0;

  // DUT ports
  logic            clock;
  logic            rst_n;
  cam_write_req_t  write_req;
  cam_search_req_t read_req;
  cam_search_req_t delete_req;
  cam_read_rsp_t   read_rsp;
  logic            full;
  logic            empty;

  // Reference model state and its predictions for the current cycle
  cam_data_t     model_store [cam_tag_t];
  cam_read_rsp_t expected_rsp;
  logic          expected_full;
  logic          expected_empty;

  // Stored tags as seen by the random stimulus, one op ahead of the model
  bit shadow_store [cam_tag_t];

  logic [31:0] lfsr_state;
  int          error_count;
  int          test_start_errors;
  int          test_number;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;

  content_addressable_memory i_dut (
    .clock      ( clock      ),
    .rst_n      ( rst_n      ),
    .write_req  ( write_req  ),
    .read_req   ( read_req   ),
    .delete_req ( delete_req ),
    .read_rsp   ( read_rsp   ),
    .full       ( full       ),
    .empty      ( empty      )
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Model update at each edge
  // Expectations computed from the state at the start of the cycle
  always @(posedge clock) begin : model_update
    int stored_before;
    if (!rst_n) begin
      model_store.delete();
      expected_rsp   <= '0;
      expected_full  <= 1'b0;
      expected_empty <= 1'b1;
    end else begin
      stored_before = model_store.num();
      // A delete strobed with the read hides the hit
      if (read_req.enable && !delete_req.enable && model_store.exists(read_req.tag)) begin
        expected_rsp.hit  <= 1'b1;
        expected_rsp.data <= model_store[read_req.tag];
      end else begin
        expected_rsp <= '0;
      end
      if (delete_req.enable && model_store.exists(delete_req.tag)) begin
        model_store.delete(delete_req.tag);
      end
      // Dropped when every slot was taken at the start of the cycle
      if (write_req.enable && stored_before < DEPTH) begin
        model_store[write_req.tag] = write_req.data;
      end
      expected_full  <= (model_store.num() == DEPTH);
      expected_empty <= (model_store.num() == 0);
    end
  end

  a_read_rsp : assert property (
    @(posedge clock) disable iff (!rst_n) read_rsp === expected_rsp
  ) else begin
    error_count = error_count + 1;
    $display("FAIL read_rsp expected %h actual %h", $sampled(expected_rsp), $sampled(read_rsp));
  end

  a_full : assert property (
    @(posedge clock) disable iff (!rst_n) full === expected_full
  ) else begin
    error_count = error_count + 1;
    $display("FAIL full expected %h actual %h", $sampled(expected_full), $sampled(full));
  end

  a_empty : assert property (
    @(posedge clock) disable iff (!rst_n) empty === expected_empty
  ) else begin
    error_count = error_count + 1;
    $display("FAIL empty expected %h actual %h", $sampled(expected_empty), $sampled(empty));
  end

  // Watchdog
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end else begin
      return state >> 1;
    end
  endfunction

  // One LFSR step per bit, the low bit shifts in
  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic cam_write_req_t write_of(input cam_tag_t tag, input cam_data_t data);
    cam_write_req_t req;
    req.enable = 1'b1;
    req.tag    = tag;
    req.data   = data;
    return req;
  endfunction

  function automatic cam_search_req_t search_of(input cam_tag_t tag);
    cam_search_req_t req;
    req.enable = 1'b1;
    req.tag    = tag;
    return req;
  endfunction

  // Inputs for one cycle, sampled by the DUT at the next edge
  task automatic drive_cycle(input cam_write_req_t wr, input cam_search_req_t rd,
                             input cam_search_req_t del);
    @(posedge clock);
    write_req  <= wr;
    read_req   <= rd;
    delete_req <= del;
  endtask

  task automatic start_test();
    test_start_errors = error_count;
    test_number       = test_number + 1;
  endtask

  // Two idle cycles let the last response reach its check
  task automatic finish_test(input string name);
    drive_cycle(NO_WRITE, NO_SEARCH, NO_SEARCH);
    drive_cycle(NO_WRITE, NO_SEARCH, NO_SEARCH);
    @(negedge clock);
    if (error_count == test_start_errors) begin
      tests_passed = tests_passed + 1;
      $display("Test %0d %s: passed", test_number, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %0d %s: failed with %0d errors", test_number, name,
               error_count - test_start_errors);
    end
  endtask

  task automatic basic_write_read();
    start_test();
    // Flags and response still at reset values
    drive_cycle(NO_WRITE, NO_SEARCH, NO_SEARCH);
    drive_cycle(write_of(8'h3c, 16'hbeef), NO_SEARCH, NO_SEARCH);
    drive_cycle(NO_WRITE, NO_SEARCH, NO_SEARCH);
    drive_cycle(NO_WRITE, search_of(8'h3c), NO_SEARCH);
    finish_test("reset state and write then read");
  endtask

  task automatic read_misses();
    start_test();
    drive_cycle(NO_WRITE, search_of(8'h55), NO_SEARCH);
    // Tag not yet visible in its own write cycle
    drive_cycle(write_of(8'h77, 16'ha5a5), search_of(8'h77), NO_SEARCH);
    drive_cycle(NO_WRITE, search_of(8'h77), NO_SEARCH);
    finish_test("read misses");
  endtask

  task automatic delete_behavior();
    start_test();
    drive_cycle(NO_WRITE, NO_SEARCH, search_of(8'h77));
    drive_cycle(NO_WRITE, search_of(8'h77), NO_SEARCH);
    // Absent tag, nothing changes
    drive_cycle(NO_WRITE, NO_SEARCH, search_of(8'h99));
    drive_cycle(NO_WRITE, search_of(8'h3c), NO_SEARCH);
    // Last stored tag, empty returns
    drive_cycle(NO_WRITE, NO_SEARCH, search_of(8'h3c));
    drive_cycle(NO_WRITE, NO_SEARCH, NO_SEARCH);
    drive_cycle(NO_WRITE, search_of(8'h3c), NO_SEARCH);
    finish_test("delete");
  endtask

  task automatic fill_to_full();
    logic [31:0] bits;
    start_test();
    for (int i = 0; i < DEPTH; i++) begin
      take_bits(16, bits);
      drive_cycle(write_of(cam_tag_t'(8'h10 + i), bits[15:0]), NO_SEARCH, NO_SEARCH);
    end
    // Dropped while full
    drive_cycle(write_of(8'hf0, 16'h0f0f), NO_SEARCH, NO_SEARCH);
    drive_cycle(NO_WRITE, search_of(8'hf0), NO_SEARCH);
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(NO_WRITE, search_of(cam_tag_t'(8'h10 + i)), NO_SEARCH);
    end
    for (int i = 0; i < DEPTH; i++) begin
      drive_cycle(NO_WRITE, NO_SEARCH, search_of(cam_tag_t'(8'h10 + i)));
    end
    finish_test("fill to full and drop");
  endtask

  task automatic same_cycle_strobes();
    start_test();
    drive_cycle(write_of(8'ha1, 16'h1111), NO_SEARCH, NO_SEARCH);
    drive_cycle(write_of(8'ha2, 16'h2222), NO_SEARCH, NO_SEARCH);
    drive_cycle(NO_WRITE, search_of(8'ha1), search_of(8'ha1));
    drive_cycle(NO_WRITE, search_of(8'ha1), NO_SEARCH);
    drive_cycle(write_of(8'ha3, 16'h3333), NO_SEARCH, search_of(8'ha2));
    drive_cycle(NO_WRITE, search_of(8'ha2), NO_SEARCH);
    drive_cycle(NO_WRITE, search_of(8'ha3), NO_SEARCH);
    drive_cycle(NO_WRITE, NO_SEARCH, search_of(8'ha3));
    finish_test("same cycle strobes");
  endtask

  // Eight tags from 8'h40, CAM starts empty
  task automatic random_traffic();
    logic [31:0]     bits;
    cam_write_req_t  wr;
    cam_search_req_t rd;
    cam_search_req_t del;
    start_test();
    shadow_store.delete();
    for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
      wr  = NO_WRITE;
      rd  = NO_SEARCH;
      del = NO_SEARCH;
      take_bits(1, bits);
      if (bits[0]) begin
        take_bits(3, bits);
        wr.tag = {5'b01000, bits[2:0]};
        take_bits(16, bits);
        wr.data = bits[15:0];
        // Only absent tags keep the stored tags unique
        wr.enable = !shadow_store.exists(wr.tag);
      end
      take_bits(1, bits);
      if (bits[0]) begin
        take_bits(3, bits);
        rd = search_of({5'b01000, bits[2:0]});
      end
      take_bits(1, bits);
      if (bits[0]) begin
        take_bits(3, bits);
        del = search_of({5'b01000, bits[2:0]});
      end
      if (del.enable && shadow_store.exists(del.tag)) begin
        shadow_store.delete(del.tag);
      end
      if (wr.enable) begin
        shadow_store[wr.tag] = 1'b1;
      end
      drive_cycle(wr, rd, del);
    end
    finish_test("random traffic");
  endtask

  initial begin
    rst_n             = 1'b0;
    write_req         = NO_WRITE;
    read_req          = NO_SEARCH;
    delete_req        = NO_SEARCH;
    lfsr_state        = LFSR_SEED;
    error_count       = 0;
    test_start_errors = 0;
    test_number       = 0;
    tests_passed      = 0;
    tests_failed      = 0;
    cycle_count       = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    rst_n <= 1'b1;
    basic_write_read();
    read_misses();
    delete_behavior();
    fill_to_full();
    same_cycle_strobes();
    random_traffic();
    $display("Tests run %0d, passed %0d, failed %0d, check failures %0d",
             test_number, tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hdl/cam_params_pkg.sv
hdl/cam_types_pkg.sv
hdl/tag_directory.sv
hdl/simple_dual_port_ram.sv
hdl/content_addressable_memory.sv
verif/cam_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the CAM testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

# Compile
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cam_tb -f build.f -o cam_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

# Run, the log decides the result
./obj_dir/cam_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
